/* verilog/parc_params.svh */
/* PARC core parameters
   Reset vector and architectural register count */

`ifndef PARC_PARAMS_SVH
`define PARC_PARAMS_SVH

// First fetch address after reset
`define PARC_RESET_VECTOR 32'h0000_0200

// Architectural registers, r0 hardwired to zero
`define PARC_NUM_REGS 32

`endif

/* verilog/parc_pkg.sv */
/* PARC core types
   Instruction encodings and datapath mux selects */

package parc_pkg;

  // Primary opcode, inst[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  // R-type function code, inst[5:0]
  typedef enum logic [5:0] {
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI
  } alu_fn_e;

  // Next PC source
  typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JUMP, PC_JUMPREG} pc_sel_e;

  // Operand source, X has the highest priority
  typedef enum logic [1:0] {BYP_RF, BYP_X, BYP_M, BYP_W} byp_sel_e;

  typedef enum logic [1:0] {OP1_RF, OP1_ZEXT, OP1_SEXT} op1_sel_e;

endpackage

/* verilog/parc_alu.sv */
/* PARC ALU
   Add, subtract, logic, signed compare and lui */

`timescale 1ns/1ps

module parc_alu import parc_pkg::*; (
  input  logic [31:0] in0,
  input  logic [31:0] in1,
  input  alu_fn_e     fn,
  output logic [31:0] out
);

  always_comb begin
    case (fn)
      ALU_ADD: out = in0 + in1;
      ALU_SUB: out = in0 - in1;
      ALU_AND: out = in0 & in1;
      ALU_OR:  out = in0 | in1;
      // Signed compare, result in bit 0
      ALU_SLT: out = {31'b0, $signed(in0) < $signed(in1)};
      // Upper immediate, in0 ignored
      ALU_LUI: out = {in1[15:0], 16'b0};
      default: out = 32'b0;
    endcase
  end

endmodule

/* verilog/parc_regfile.sv */
/* PARC register file
   Two combinational reads, one synchronous write, r0 reads zero */

`timescale 1ns/1ps
`include "parc_params.svh"

module parc_regfile (
  input  logic        clk,
  input  logic [4:0]  raddr0,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata0,
  output logic [31:0] rdata1,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0] regs [0:`PARC_NUM_REGS-1];

  // r0 never stored, masked on read
  assign rdata0 = (raddr0 == 5'd0) ? 32'b0 : regs[raddr0];
  assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];

  always_ff @(posedge clk) begin
    if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

/* verilog/parc_dpath.sv */
/* PARC datapath
   PC select, pipeline registers, bypass network, ALU and writeback */

`timescale 1ns/1ps
`include "parc_params.svh"

module parc_dpath import parc_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,
  output logic [31:0] inst_d,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  input  logic [31:0] dmem_rdata,
  input  pc_sel_e     pc_sel,
  input  byp_sel_e    rs_byp_sel,
  input  byp_sel_e    rt_byp_sel,
  input  op1_sel_e    op1_sel,
  input  alu_fn_e     alu_fn_x,
  input  logic        wb_sel_m,
  input  logic        rf_wen_w,
  input  logic [4:0]  rf_waddr_w,
  input  logic        stall_f,
  input  logic        stall_d,
  input  logic        squash_d,
  input  logic        squash_x,
  output logic        br_eq_x,
  output logic        br_ne_x
);

  // PC path
  logic [31:0] pc_mux_p;
  logic [31:0] pc_next_p;
  logic [31:0] pc_f;
  logic [31:0] pc_plus4_f;
  logic [31:0] pc_plus4_d;
  // Decode
  logic [31:0] imm_sext_d;
  logic [31:0] imm_zext_d;
  logic [31:0] branch_targ_d;
  logic [31:0] jump_targ_d;
  logic [31:0] jumpreg_targ_d;
  logic [31:0] rf_rdata0_d;
  logic [31:0] rf_rdata1_d;
  logic [31:0] rs_byp_d;
  logic [31:0] rt_byp_d;
  logic [31:0] op1_d;
  // Execute onwards
  logic [31:0] branch_targ_x;
  logic [31:0] rs_val_x;
  logic [31:0] rt_val_x;
  logic [31:0] op1_x;
  logic [31:0] alu_out_x;
  logic [31:0] alu_out_m;
  logic [31:0] wb_data_m;
  logic [31:0] wb_data_w;

  // Four-way bypass, shared by rs and rt
  function automatic logic [31:0] byp_mux(input byp_sel_e sel, input logic [31:0] rf_val,
                                          input logic [31:0] x_val, input logic [31:0] m_val,
                                          input logic [31:0] w_val);
    case (sel)
      BYP_X:   byp_mux = x_val;
      BYP_M:   byp_mux = m_val;
      BYP_W:   byp_mux = w_val;
      default: byp_mux = rf_val;
    endcase
  endfunction

  // ----------------------------------------
  // P and F stages
  // ----------------------------------------

  // Branch from X, jumps from D
  always_comb begin
    case (pc_sel)
      PC_BRANCH:  pc_mux_p = branch_targ_x;
      PC_JUMP:    pc_mux_p = jump_targ_d;
      PC_JUMPREG: pc_mux_p = jumpreg_targ_d;
      default:    pc_mux_p = pc_plus4_f;
    endcase
  end

  // On stall refetch the F address so imem returns the same word
  assign pc_next_p = stall_f ? pc_f : pc_mux_p;
  assign imem_addr = reset ? `PARC_RESET_VECTOR : pc_next_p;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= `PARC_RESET_VECTOR;
    end else begin
      pc_f <= pc_next_p;
    end
  end

  assign pc_plus4_f = pc_f + 32'd4;

  // ----------------------------------------
  // D stage
  // ----------------------------------------

  // Squashed slot becomes all-zero nop
  always_ff @(posedge clk) begin
    if (reset || squash_d) begin
      inst_d <= 32'b0;
    end else if (!stall_d) begin
      inst_d <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_d) begin
      pc_plus4_d <= pc_plus4_f;
    end
  end

  assign imm_sext_d    = {{16{inst_d[15]}}, inst_d[15:0]};
  assign imm_zext_d    = {16'b0, inst_d[15:0]};
  assign branch_targ_d = pc_plus4_d + {imm_sext_d[29:0], 2'b00};
  assign jump_targ_d   = {pc_plus4_d[31:28], inst_d[25:0], 2'b00};

  parc_regfile rfile0 (
    .clk    (clk),
    .raddr0 (inst_d[25:21]),
    .raddr1 (inst_d[20:16]),
    .rdata0 (rf_rdata0_d),
    .rdata1 (rf_rdata1_d),
    .wen    (rf_wen_w),
    .waddr  (rf_waddr_w),
    .wdata  (wb_data_w)
  );

  // W forward covers the same-cycle regfile write
  assign rs_byp_d = byp_mux(rs_byp_sel, rf_rdata0_d, alu_out_x, wb_data_m, wb_data_w);
  assign rt_byp_d = byp_mux(rt_byp_sel, rf_rdata1_d, alu_out_x, wb_data_m, wb_data_w);

  assign jumpreg_targ_d = rs_byp_d;

  always_comb begin
    case (op1_sel)
      OP1_ZEXT: op1_d = imm_zext_d;
      OP1_SEXT: op1_d = imm_sext_d;
      default:  op1_d = rt_byp_d;
    endcase
  end

  // ----------------------------------------
  // X stage
  // ----------------------------------------

  // Bubbles enter X with zeroed operands
  always_ff @(posedge clk) begin
    if (squash_x || stall_d) begin
      rs_val_x <= 32'b0;
      rt_val_x <= 32'b0;
      op1_x    <= 32'b0;
    end else begin
      rs_val_x <= rs_byp_d;
      rt_val_x <= rt_byp_d;
      op1_x    <= op1_d;
    end
    branch_targ_x <= branch_targ_d;
  end

  parc_alu alu0 (
    .in0 (rs_val_x),
    .in1 (op1_x),
    .fn  (alu_fn_x),
    .out (alu_out_x)
  );

  // Branch condition on the bypassed sources
  assign br_eq_x = (rs_val_x == rt_val_x);
  assign br_ne_x = !br_eq_x;

  // Data request leaves in X, load data returns in M
  assign dmem_addr  = alu_out_x;
  assign dmem_wdata = rt_val_x;

  // ----------------------------------------
  // M and W stages
  // ----------------------------------------

  always_ff @(posedge clk) begin
    alu_out_m <= alu_out_x;
    wb_data_w <= wb_data_m;
  end

  assign wb_data_m = wb_sel_m ? dmem_rdata : alu_out_m;

endmodule

/* verilog/parc_ctrl.sv */
/* PARC control unit
   Decode, control pipeline, bypass selects, load-use stall and squashes */

`timescale 1ns/1ps

module parc_ctrl import parc_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] inst_d,
  input  logic        br_eq_x,
  input  logic        br_ne_x,
  output pc_sel_e     pc_sel,
  output byp_sel_e    rs_byp_sel,
  output byp_sel_e    rt_byp_sel,
  output op1_sel_e    op1_sel,
  output alu_fn_e     alu_fn_x,
  output logic        dmem_wen,
  output logic        wb_sel_m,
  output logic        rf_wen_w,
  output logic [4:0]  rf_waddr_w,
  output logic        stall_f,
  output logic        stall_d,
  output logic        squash_d,
  output logic        squash_x
);

  opcode_e    opcode_d;
  funct_e     funct_d;
  logic [4:0] rs_d;
  logic [4:0] rt_d;
  // Decoded control word
  logic       rs_en_d;
  logic       rt_en_d;
  logic       wen_d;
  logic [4:0] dest_d;
  logic       rf_wen_d;
  logic       load_d;
  logic       store_d;
  logic       beq_d;
  logic       bne_d;
  logic       j_d;
  logic       jr_d;
  alu_fn_e    alu_fn_d;
  // Control pipeline
  logic       rf_wen_x;
  logic [4:0] waddr_x;
  logic       load_x;
  logic       store_x;
  logic       beq_x;
  logic       bne_x;
  logic       rf_wen_m;
  logic [4:0] waddr_m;
  logic       load_m;
  // Hazards
  logic       load_use;
  logic       br_taken_x;
  logic       jump_d;

  assign opcode_d = opcode_e'(inst_d[31:26]);
  assign funct_d  = funct_e'(inst_d[5:0]);
  assign rs_d     = inst_d[25:21];
  assign rt_d     = inst_d[20:16];

  // ----------------------------------------
  // Decode
  // ----------------------------------------

  always_comb begin
    rs_en_d  = 1'b0;
    rt_en_d  = 1'b0;
    wen_d    = 1'b0;
    dest_d   = inst_d[15:11];
    load_d   = 1'b0;
    store_d  = 1'b0;
    beq_d    = 1'b0;
    bne_d    = 1'b0;
    j_d      = 1'b0;
    jr_d     = 1'b0;
    alu_fn_d = ALU_ADD;
    op1_sel  = OP1_RF;
    case (opcode_d)
      OP_RTYPE: begin
        rs_en_d = 1'b1;
        rt_en_d = 1'b1;
        wen_d   = 1'b1;
        case (funct_d)
          FN_ADDU: alu_fn_d = ALU_ADD;
          FN_SUBU: alu_fn_d = ALU_SUB;
          FN_AND:  alu_fn_d = ALU_AND;
          FN_OR:   alu_fn_d = ALU_OR;
          FN_SLT:  alu_fn_d = ALU_SLT;
          FN_JR: begin
            rt_en_d = 1'b0;
            wen_d   = 1'b0;
            jr_d    = 1'b1;
          end
          // Unknown funct, including the nop, does nothing
          default: wen_d = 1'b0;
        endcase
      end
      OP_ADDIU: begin
        rs_en_d = 1'b1;
        wen_d   = 1'b1;
        dest_d  = rt_d;
        op1_sel = OP1_SEXT;
      end
      OP_ORI: begin
        rs_en_d  = 1'b1;
        wen_d    = 1'b1;
        dest_d   = rt_d;
        op1_sel  = OP1_ZEXT;
        alu_fn_d = ALU_OR;
      end
      OP_LUI: begin
        wen_d    = 1'b1;
        dest_d   = rt_d;
        op1_sel  = OP1_ZEXT;
        alu_fn_d = ALU_LUI;
      end
      OP_LW: begin
        rs_en_d = 1'b1;
        wen_d   = 1'b1;
        dest_d  = rt_d;
        op1_sel = OP1_SEXT;
        load_d  = 1'b1;
      end
      OP_SW: begin
        rs_en_d = 1'b1;
        rt_en_d = 1'b1;
        op1_sel = OP1_SEXT;
        store_d = 1'b1;
      end
      OP_BEQ: begin
        rs_en_d = 1'b1;
        rt_en_d = 1'b1;
        beq_d   = 1'b1;
      end
      OP_BNE: begin
        rs_en_d = 1'b1;
        rt_en_d = 1'b1;
        bne_d   = 1'b1;
      end
      OP_J:    j_d = 1'b1;
      default: ;
    endcase
  end

  // Writes to r0 dropped here, so r0 never matches a bypass
  assign rf_wen_d = wen_d && (dest_d != 5'd0);

  // ----------------------------------------
  // Control pipeline X, M, W
  // ----------------------------------------

  // Load-use stall and branch squash both insert an X bubble
  always_ff @(posedge clk) begin
    if (reset || squash_x || stall_d) begin
      rf_wen_x <= 1'b0;
      waddr_x  <= 5'd0;
      load_x   <= 1'b0;
      store_x  <= 1'b0;
      beq_x    <= 1'b0;
      bne_x    <= 1'b0;
      alu_fn_x <= ALU_ADD;
    end else begin
      rf_wen_x <= rf_wen_d;
      waddr_x  <= dest_d;
      load_x   <= load_d;
      store_x  <= store_d;
      beq_x    <= beq_d;
      bne_x    <= bne_d;
      alu_fn_x <= alu_fn_d;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rf_wen_m   <= 1'b0;
      waddr_m    <= 5'd0;
      load_m     <= 1'b0;
      rf_wen_w   <= 1'b0;
      rf_waddr_w <= 5'd0;
    end else begin
      rf_wen_m   <= rf_wen_x;
      waddr_m    <= waddr_x;
      load_m     <= load_x;
      rf_wen_w   <= rf_wen_m;
      rf_waddr_w <= waddr_m;
    end
  end

  assign dmem_wen = store_x;
  assign wb_sel_m = load_m;

  // ----------------------------------------
  // Bypass and hazards
  // ----------------------------------------

  // Youngest producer wins
  function automatic byp_sel_e pick_byp(input logic en, input logic [4:0] src);
    if (en && rf_wen_x && (waddr_x == src)) begin
      pick_byp = BYP_X;
    end else if (en && rf_wen_m && (waddr_m == src)) begin
      pick_byp = BYP_M;
    end else if (en && rf_wen_w && (rf_waddr_w == src)) begin
      pick_byp = BYP_W;
    end else begin
      pick_byp = BYP_RF;
    end
  endfunction

  assign rs_byp_sel = pick_byp(rs_en_d, rs_d);
  assign rt_byp_sel = pick_byp(rt_en_d, rt_d);

  // Load data not ready until M
  assign load_use = load_x && rf_wen_x &&
                    ((rs_en_d && (waddr_x == rs_d)) || (rt_en_d && (waddr_x == rt_d)));

  assign br_taken_x = (beq_x && br_eq_x) || (bne_x && br_ne_x);
  // Stalled jr waits for its operand
  assign jump_d     = (j_d || jr_d) && !load_use;

  always_comb begin
    if (br_taken_x) begin
      pc_sel = PC_BRANCH;
    end else if (jump_d) begin
      pc_sel = jr_d ? PC_JUMPREG : PC_JUMP;
    end else begin
      pc_sel = PC_PLUS4;
    end
  end

  assign stall_f  = load_use;
  assign stall_d  = load_use;
  // Taken branch kills D and F, jump kills F
  assign squash_d = br_taken_x || jump_d;
  assign squash_x = br_taken_x;

endmodule

/* verilog/parc_core.sv */
/* PARC five-stage core
   Control unit and datapath joined, memories are external */

`timescale 1ns/1ps

module parc_core import parc_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  output logic        dmem_wen,
  input  logic [31:0] dmem_rdata
);

  // ctrl -> dpath
  pc_sel_e     pc_sel;
  byp_sel_e    rs_byp_sel;
  byp_sel_e    rt_byp_sel;
  op1_sel_e    op1_sel;
  alu_fn_e     alu_fn_x;
  logic        wb_sel_m;
  logic        rf_wen_w;
  logic [4:0]  rf_waddr_w;
  logic        stall_f;
  logic        stall_d;
  logic        squash_d;
  logic        squash_x;
  // dpath -> ctrl
  logic [31:0] inst_d;
  logic        br_eq_x;
  logic        br_ne_x;

  parc_ctrl ctrl0 (
    .clk        (clk),
    .reset      (reset),
    .inst_d     (inst_d),
    .br_eq_x    (br_eq_x),
    .br_ne_x    (br_ne_x),
    .pc_sel     (pc_sel),
    .rs_byp_sel (rs_byp_sel),
    .rt_byp_sel (rt_byp_sel),
    .op1_sel    (op1_sel),
    .alu_fn_x   (alu_fn_x),
    .dmem_wen   (dmem_wen),
    .wb_sel_m   (wb_sel_m),
    .rf_wen_w   (rf_wen_w),
    .rf_waddr_w (rf_waddr_w),
    .stall_f    (stall_f),
    .stall_d    (stall_d),
    .squash_d   (squash_d),
    .squash_x   (squash_x)
  );

  parc_dpath dpath0 (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .inst_d     (inst_d),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .pc_sel     (pc_sel),
    .rs_byp_sel (rs_byp_sel),
    .rt_byp_sel (rt_byp_sel),
    .op1_sel    (op1_sel),
    .alu_fn_x   (alu_fn_x),
    .wb_sel_m   (wb_sel_m),
    .rf_wen_w   (rf_wen_w),
    .rf_waddr_w (rf_waddr_w),
    .stall_f    (stall_f),
    .stall_d    (stall_d),
    .squash_d   (squash_d),
    .squash_x   (squash_x),
    .br_eq_x    (br_eq_x),
    .br_ne_x    (br_ne_x)
  );

endmodule

/* verif/tb_parc_core.sv */
/* PARC core testbench
   Random programs per test with stores checked in order against an ISA interpreter */

`timescale 1ns/1ps
`include "parc_params.svh"

module tb_parc_core import parc_pkg::*; ();

  logic        clk;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_wen;
  logic [31:0] dmem_rdata;

  // Word arrays with the program at the reset vector
  logic [31:0] imem [0:511];
  logic [31:0] dmem [0:255];
  // Expected store stream from the interpreter
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_a;
  logic [31:0] exp_d;
  // Memory model samples taken at the edge
  logic [31:0] ia_s;
  logic [31:0] da_s;
  logic [31:0] dw_s;
  logic        we_s;
  int unsigned wp;
  int          store_count;
  int          errors;
  int          pass_count;
  int          fail_count;
  string       cur_test;
  string       names [0:5] = '{"alu", "bypass", "load_use", "branch", "jump", "reg_zero"};

  parc_core dut0 (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wen   (dmem_wen),
    .dmem_rdata (dmem_rdata)
  );

  always #50 clk = ~clk;

  // ----------------------------------------
  // Memory models
  // ----------------------------------------

  // Address taken at the edge and data back 1 ns later
  always @(posedge clk) begin
    ia_s = imem_addr;
    da_s = dmem_addr;
    dw_s = dmem_wdata;
    we_s = dmem_wen;
    #1;
    imem_data  = imem[ia_s[10:2]];
    // Read before write since loads never share a cycle with stores
    dmem_rdata = dmem[da_s[9:2]];
    if (we_s) begin
      dmem[da_s[9:2]] = dw_s;
    end
  end

  // Initial data contents spread over the whole word index
  function automatic logic [31:0] fill_word(input int idx);
    return 32'(idx) * 32'h9e37_79b1 + 32'h0bad_f00d;
  endfunction

  // ----------------------------------------
  // Instruction encoding
  // ----------------------------------------

  function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [5:0] fn);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Absolute byte target with the upper nibble from the PC
  function automatic logic [31:0] jump_word(input logic [31:0] tgt);
    logic [5:0] op;
    op = OP_J;
    return {op, tgt[27:2]};
  endfunction

  // Sources come from r1..r15 as set up by the prologue
  function automatic logic [4:0] pick_reg();
    return 5'($urandom_range(1, 15));
  endfunction

  function automatic logic [15:0] random_imm();
    return 16'($urandom());
  endfunction

  // Word aligned and inside the 1 KB data array
  function automatic logic [15:0] word_offset();
    return {6'd0, 8'($urandom_range(0, 255)), 2'b00};
  endfunction

  function automatic void emit(input logic [31:0] inst);
    imem[wp] = inst;
    wp++;
  endfunction

  // sw with r0 as base
  function automatic void emit_store(input logic [4:0] rt);
    emit(itype_word(OP_SW, 5'd0, rt, word_offset()));
  endfunction

  // ----------------------------------------
  // Program generator
  // ----------------------------------------

  function automatic void build_program(input int id);
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rc;
    logic [5:0]  op;
    logic [15:0] off;
    logic [31:0] tgt;
    int          reps;
    wp = `PARC_RESET_VECTOR >> 2;
    // Prologue gives every source register a known value
    for (int r = 1; r < 16; r++) begin
      emit(itype_word(OP_ADDIU, 5'd0, 5'(r), random_imm()));
    end
    reps = (id == 0) ? 2 : 4;
    for (int k = 0; k < reps; k++) begin
      ra = pick_reg();
      rb = pick_reg();
      rc = pick_reg();
      case (id)
        0: begin
          // Eight independent results and then their stores
          emit(rtype_word(ra, rb, 5'd16, FN_ADDU));
          emit(rtype_word(ra, rb, 5'd17, FN_SUBU));
          emit(rtype_word(ra, rc, 5'd18, FN_AND));
          emit(rtype_word(rb, rc, 5'd19, FN_OR));
          emit(rtype_word(ra, rb, 5'd20, FN_SLT));
          emit(itype_word(OP_ADDIU, rc, 5'd21, random_imm()));
          emit(itype_word(OP_ORI, ra, 5'd22, random_imm()));
          emit(itype_word(OP_LUI, 5'd0, 5'd23, random_imm()));
          for (int r = 16; r < 24; r++) begin
            emit_store(5'(r));
          end
        end
        1: begin
          // r24 read at distance 1, 2 and 3
          emit(rtype_word(ra, rb, 5'd24, FN_ADDU));
          emit(rtype_word(5'd24, rc, 5'd25, FN_SUBU));
          emit(rtype_word(ra, 5'd24, 5'd26, FN_OR));
          emit(rtype_word(5'd24, 5'd25, 5'd27, FN_SLT));
          emit_store(5'd27);
          emit_store(5'd26);
          emit_store(5'd25);
          emit_store(5'd24);
        end
        2: begin
          off = word_offset();
          emit(itype_word(OP_SW, 5'd0, ra, off));
          emit(itype_word(OP_LW, 5'd0, 5'd28, off));
          // Use right behind the load
          emit(rtype_word(5'd28, rb, 5'd29, FN_ADDU));
          emit_store(5'd29);
          emit(itype_word(OP_LW, 5'd0, 5'd30, word_offset()));
          // Store data is the loaded register
          emit_store(5'd30);
          emit(itype_word(OP_LW, 5'd0, 5'd31, word_offset()));
          emit(itype_word(OP_ADDIU, 5'd31, 5'd31, random_imm()));
          emit_store(5'd31);
        end
        3: begin
          // Rep index picks beq or bne and equal or distinct operands
          op = (k[0] == 1'b0) ? OP_BEQ : OP_BNE;
          if (k[1]) begin
            rb = ra;
          end else if (rb == ra) begin
            rb = (ra == 5'd15) ? 5'd1 : ra + 5'd1;
          end
          // Branch operand comes straight from the X bypass
          emit(rtype_word(ra, 5'd0, 5'd24, FN_OR));
          emit(itype_word(op, 5'd24, rb, 16'd2));
          emit_store(rc);
          emit_store(rc);
          emit_store(rb);
        end
        4: begin
          // j over two stores
          tgt = (wp + 3) << 2;
          emit(jump_word(tgt));
          emit_store(rc);
          emit_store(rc);
          emit_store(ra);
          // jr target made one instruction earlier
          tgt = (wp + 3) << 2;
          emit(itype_word(OP_ADDIU, 5'd0, 5'd25, tgt[15:0]));
          emit(rtype_word(5'd25, 5'd0, 5'd0, FN_JR));
          emit_store(rc);
          emit_store(rb);
        end
        default: begin
          // Every r0 write must vanish
          emit(itype_word(OP_ADDIU, ra, 5'd0, random_imm()));
          emit(rtype_word(ra, rb, 5'd0, FN_ADDU));
          emit_store(5'd0);
          emit(itype_word(OP_LW, 5'd0, 5'd0, word_offset()));
          emit_store(5'd0);
          emit(rtype_word(5'd0, ra, 5'd24, FN_OR));
          emit_store(5'd24);
        end
      endcase
    end
    // Park on a jump to itself
    emit(jump_word(wp << 2));
  endfunction

  // ----------------------------------------
  // Reference interpreter
  // ----------------------------------------

  // Runs the program in order without a delay slot and records each store
  function automatic void interp_program();
    logic [31:0] rf [0:`PARC_NUM_REGS-1];
    logic [31:0] dm [0:255];
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] ea;
    logic [31:0] res;
    logic [31:0] nxt;
    logic [4:0]  dst;
    logic        wr;
    for (int i = 0; i < `PARC_NUM_REGS; i++) begin
      rf[i] = 32'b0;
    end
    for (int i = 0; i < 256; i++) begin
      dm[i] = fill_word(i);
    end
    pc = `PARC_RESET_VECTOR;
    for (int step = 0; step < 4000; step++) begin
      inst = imem[pc[10:2]];
      a    = rf[inst[25:21]];
      b    = rf[inst[20:16]];
      sx   = {{16{inst[15]}}, inst[15:0]};
      ea   = a + sx;
      nxt  = pc + 4;
      dst  = inst[20:16];
      res  = 32'b0;
      wr   = 1'b0;
      case (inst[31:26])
        OP_RTYPE: begin
          wr  = 1'b1;
          dst = inst[15:11];
          case (inst[5:0])
            FN_ADDU: res = a + b;
            FN_SUBU: res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
            FN_JR: begin
              wr  = 1'b0;
              nxt = a;
            end
            default: wr = 1'b0;
          endcase
        end
        OP_ADDIU: begin
          wr  = 1'b1;
          res = ea;
        end
        OP_ORI: begin
          wr  = 1'b1;
          res = a | {16'b0, inst[15:0]};
        end
        OP_LUI: begin
          wr  = 1'b1;
          res = {inst[15:0], 16'b0};
        end
        OP_LW: begin
          wr  = 1'b1;
          res = dm[ea[9:2]];
        end
        OP_SW: begin
          dm[ea[9:2]] = b;
          exp_addr.push_back(ea);
          exp_data.push_back(b);
        end
        OP_BEQ: if (a == b) nxt = pc + 4 + (sx << 2);
        OP_BNE: if (a != b) nxt = pc + 4 + (sx << 2);
        OP_J:   nxt = {nxt[31:28], inst[25:0], 2'b00};
        default: ;
      endcase
      // Self loop ends the program
      if (nxt == pc) break;
      if (wr && (dst != 5'd0)) rf[dst] = res;
      pc = nxt;
    end
  endfunction

  // ----------------------------------------
  // Checking
  // ----------------------------------------

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  // Every store on the bus must be the next expected one
  always @(posedge clk) begin
    if (!reset && dmem_wen) begin
      if (exp_addr.size() == 0) begin
        $display("ERROR %s: unexpected store of %h to %h", cur_test, dmem_wdata, dmem_addr);
        errors++;
      end else begin
        exp_a = exp_addr.pop_front();
        exp_d = exp_data.pop_front();
        check_value("store addr", exp_a, dmem_addr);
        check_value("store data", exp_d, dmem_wdata);
      end
      store_count++;
    end
  end

  task automatic run_test(input int id);
    int errs_before;
    int n;
    int cycles;
    @(posedge clk);
    #1;
    reset    = 1'b1;
    cur_test = names[id];
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 512; i++) begin
      imem[i] = 32'b0;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = fill_word(i);
    end
    build_program(id);
    interp_program();
    n           = exp_addr.size();
    errs_before = errors;
    store_count = 0;
    // Five reset edges
    for (int c = 0; c < 5; c++) begin
      @(posedge clk);
      #1;
    end
    reset  = 1'b0;
    cycles = 0;
    while ((store_count < n) && (cycles < 2000)) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (store_count < n) begin
      $display("ERROR %s: timed out with %0d of %0d stores seen", cur_test, store_count, n);
      errors++;
    end else begin
      // Drain window where squashed stores would show up
      for (int c = 0; c < 20; c++) begin
        @(posedge clk);
        #1;
      end
    end
    if (errors == errs_before) begin
      pass_count++;
      $display("test %-9s ok   (%0d stores)", cur_test, n);
    end else begin
      fail_count++;
      $display("test %-9s bad  (%0d errors)", cur_test, errors - errs_before);
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    imem_data   = 32'b0;
    dmem_rdata  = 32'b0;
    errors      = 0;
    pass_count  = 0;
    fail_count  = 0;
    store_count = 0;
    void'($urandom(9));
    for (int t = 0; t < 6; t++) begin
      run_test(t);
    end
    $display("tests ok %0d, bad %0d, errors %0d", pass_count, fail_count, errors);
    if ((fail_count == 0) && (errors == 0)) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* parc_core.f */
+incdir+verilog
verilog/parc_pkg.sv
verilog/parc_alu.sv
verilog/parc_regfile.sv
verilog/parc_dpath.sv
verilog/parc_ctrl.sv
verilog/parc_core.sv
verif/tb_parc_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the PARC core testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_parc_core \
  -Mdir obj_dir -f parc_core.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_parc_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "*** PASSED ***" "$LOG"; then
  exit 0
fi
exit 1
